// ==== design/avm_pkg.sv ====
package avm_pkg;

    // Avalon-MM bus types
    typedef logic [4:0]  avm_addr_t;
    typedef logic [31:0] avm_data_t;

    // UART register byte addresses
    localparam avm_addr_t RX_ADDR     = 5'd0;
    localparam avm_addr_t TX_ADDR     = 5'd4;
    localparam avm_addr_t STATUS_ADDR = 5'd8;

    // status word bits
    localparam int TX_OK_BIT = 6;
    localparam int RX_OK_BIT = 7;

endpackage

// ==== design/rsa_pkg.sv ====
package rsa_pkg;

    typedef logic [7:0] byte_t;
    typedef logic [5:0] byte_cnt_t;  // up to 32 bytes per operand

    // bus wrapper FSM
    typedef enum logic [2:0] {
        POLL_RX,
        READ_RX,
        POLL_TX,
        WRITE_TX,
        WAIT_CORE
    } wrap_state_t;

    // exponentiation core FSM
    typedef enum logic [2:0] {
        IDLE,
        PREP,
        MULT,
        SQUARE,
        FINISH
    } core_state_t;

endpackage

// ==== design/rsa_job_if.sv ====
interface rsa_job_if #(
    parameter int KEY_BITS = 256
);

    logic                start;     // one-cycle pulse
    logic [KEY_BITS-1:0] n;
    logic [KEY_BITS-1:0] d;
    logic [KEY_BITS-1:0] a;
    logic [KEY_BITS-1:0] result;    // valid with finished
    logic                finished;  // one-cycle pulse

    modport wrapper (
        output start, n, d, a,
        input  result, finished
    );

    modport core (
        input  start, n, d, a,
        output result, finished
    );

endinterface

// ==== design/rsa_prep.sv ====
module rsa_prep #(
    parameter int KEY_BITS = 256
) (
    input  logic                avm_clk,
    input  logic                avm_rst,
    input  logic                start,
    input  logic [KEY_BITS-1:0] a,
    input  logic [KEY_BITS-1:0] n,
    output logic [KEY_BITS-1:0] result,
    output logic                done
);

    localparam int CW = $clog2(KEY_BITS + 1);

    logic [KEY_BITS-1:0] rem;   // always below n
    logic [KEY_BITS:0]   dbl;
    logic [KEY_BITS:0]   diff;
    logic [CW-1:0]       cnt;
    logic                busy;
    logic                last;

    assign dbl    = {rem, 1'b0};
    assign diff   = dbl - {1'b0, n};
    assign last   = cnt == CW'(KEY_BITS);
    assign result = rem;

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                if (last) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge avm_clk) begin
        if (start) begin
            rem <= a;
        end else if (busy && !last) begin
            rem <= (dbl >= {1'b0, n}) ? diff[KEY_BITS-1:0] : dbl[KEY_BITS-1:0];
        end
    end

endmodule

// ==== design/rsa_mont.sv ====
module rsa_mont #(
    parameter int KEY_BITS = 256
) (
    input  logic                avm_clk,
    input  logic                avm_rst,
    input  logic                start,
    input  logic [KEY_BITS-1:0] x,
    input  logic [KEY_BITS-1:0] y,
    input  logic [KEY_BITS-1:0] n,
    output logic [KEY_BITS-1:0] result,
    output logic                done
);

    localparam int CW = $clog2(KEY_BITS + 1);

    logic [KEY_BITS+1:0] acc;      // stays below 2n
    logic [KEY_BITS+1:0] acc_add;
    logic [KEY_BITS+1:0] acc_odd;
    logic [KEY_BITS-1:0] x_sr;
    logic [CW-1:0]       cnt;
    logic                busy;
    logic                last;

    assign acc_add = acc + (x_sr[0] ? {2'b00, y} : '0);
    assign acc_odd = acc_add[0] ? acc_add + {2'b00, n} : acc_add;  // make it even
    assign last    = cnt == CW'(KEY_BITS);
    assign result  = acc[KEY_BITS-1:0];

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                if (last) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge avm_clk) begin
        if (start) begin
            acc  <= '0;
            x_sr <= x;
        end else if (busy) begin
            if (!last) begin
                acc  <= acc_odd >> 1;
                x_sr <= x_sr >> 1;
            end else if (acc >= {2'b00, n}) begin
                acc <= acc - {2'b00, n};  // final reduction
            end
        end
    end

endmodule

// ==== design/rsa_core.sv ====
module rsa_core #(
    parameter int KEY_BITS = 256
) (
    input  logic    avm_clk,
    input  logic    avm_rst,
    rsa_job_if.core job
);
    import rsa_pkg::*;

    localparam int BW = $clog2(KEY_BITS);

    core_state_t         state;
    logic [BW-1:0]       bit_cnt;
    logic                last_bit;
    logic                prep_start;
    logic                prep_done;
    logic [KEY_BITS-1:0] prep_result;
    logic                mont_start;
    logic                mont_done;
    logic [KEY_BITS-1:0] mont_x;
    logic [KEY_BITS-1:0] mont_y;
    logic [KEY_BITS-1:0] mont_result;
    logic [KEY_BITS-1:0] acc;   // plain form
    logic [KEY_BITS-1:0] base;  // montgomery form
    logic [KEY_BITS-1:0] d_sr;

    assign mont_x   = (state == MULT) ? acc : base;
    assign mont_y   = base;
    assign last_bit = bit_cnt == BW'(KEY_BITS - 1);

    assign job.result   = acc;
    assign job.finished = state == FINISH;

    rsa_prep #(.KEY_BITS(KEY_BITS)) u_prep (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (prep_start),
        .a       (job.a),
        .n       (job.n),
        .result  (prep_result),
        .done    (prep_done)
    );

    rsa_mont #(.KEY_BITS(KEY_BITS)) u_mont (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (mont_start),
        .x       (mont_x),
        .y       (mont_y),
        .n       (job.n),
        .result  (mont_result),
        .done    (mont_done)
    );

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state      <= IDLE;
            bit_cnt    <= '0;
            prep_start <= 1'b0;
            mont_start <= 1'b0;
        end else begin
            prep_start <= 1'b0;
            mont_start <= 1'b0;
            case (state)
                IDLE: begin
                    if (job.start) begin
                        prep_start <= 1'b1;
                        bit_cnt    <= '0;
                        state      <= PREP;
                    end
                end
                PREP: begin
                    if (prep_done) begin
                        mont_start <= 1'b1;
                        state      <= d_sr[0] ? MULT : SQUARE;
                    end
                end
                MULT: begin
                    if (mont_done) begin
                        mont_start <= 1'b1;
                        state      <= SQUARE;
                    end
                end
                SQUARE: begin
                    if (mont_done) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (last_bit) begin
                            state <= FINISH;
                        end else begin
                            mont_start <= 1'b1;
                            state      <= d_sr[1] ? MULT : SQUARE;  // peek next bit
                        end
                    end
                end
                FINISH:  state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge avm_clk) begin
        case (state)
            IDLE: begin
                if (job.start) begin
                    d_sr <= job.d;
                    acc  <= KEY_BITS'(1);
                end
            end
            PREP:   if (prep_done) base <= prep_result;
            MULT:   if (mont_done) acc <= mont_result;
            SQUARE: begin
                if (mont_done) begin
                    base <= mont_result;
                    d_sr <= d_sr >> 1;
                end
            end
            default: ;
        endcase
    end

endmodule

// ==== design/rsa_avm_wrapper.sv ====
module rsa_avm_wrapper #(
    parameter int KEY_BITS = 256
) (
    input  logic               avm_clk,
    input  logic               avm_rst,
    output avm_pkg::avm_addr_t avm_address,
    output logic               avm_read,
    input  avm_pkg::avm_data_t avm_readdata,
    output logic               avm_write,
    output avm_pkg::avm_data_t avm_writedata,
    input  logic               avm_waitrequest,
    rsa_job_if.wrapper         job
);
    import avm_pkg::*;
    import rsa_pkg::*;

    localparam int BYTES = KEY_BITS / 8;

    typedef enum logic [1:0] {
        PH_N,
        PH_D,
        PH_A
    } phase_t;

    wrap_state_t           state;
    phase_t                phase;
    byte_cnt_t             byte_cnt;
    logic                  start;
    logic [3*KEY_BITS-1:0] op_sr;   // n, d, a in arrival order
    logic [KEY_BITS-1:0]   res_sr;
    byte_t                 rx_byte;
    byte_t                 tx_byte;
    logic                  xfer_done;

    assign xfer_done     = !avm_waitrequest;
    assign rx_byte       = avm_readdata[7:0];
    assign tx_byte       = res_sr[KEY_BITS-9 -: 8];  // top byte is never sent
    assign avm_writedata = avm_data_t'(tx_byte);

    assign job.start = start;
    assign job.n     = op_sr[3*KEY_BITS-1 -: KEY_BITS];
    assign job.d     = op_sr[2*KEY_BITS-1 -: KEY_BITS];
    assign job.a     = op_sr[KEY_BITS-1:0];

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state       <= POLL_RX;
            phase       <= PH_N;
            byte_cnt    <= '0;
            start       <= 1'b0;
            avm_read    <= 1'b0;
            avm_write   <= 1'b0;
            avm_address <= STATUS_ADDR;
        end else begin
            start <= 1'b0;
            case (state)
                POLL_RX: begin
                    if (avm_read && xfer_done && avm_readdata[RX_OK_BIT]) begin
                        avm_address <= RX_ADDR;
                        state       <= READ_RX;
                    end else begin
                        avm_read    <= 1'b1;  // keep polling status
                        avm_address <= STATUS_ADDR;
                    end
                end
                READ_RX: begin
                    if (xfer_done) begin
                        avm_address <= STATUS_ADDR;
                        state       <= POLL_RX;
                        if (byte_cnt == byte_cnt_t'(BYTES - 1)) begin
                            byte_cnt <= '0;
                            case (phase)
                                PH_N: phase <= PH_D;
                                PH_D: phase <= PH_A;
                                default: begin
                                    phase    <= PH_N;
                                    avm_read <= 1'b0;  // bus idle while core runs
                                    start    <= 1'b1;
                                    state    <= WAIT_CORE;
                                end
                            endcase
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                end
                WAIT_CORE: begin
                    if (job.finished) begin
                        avm_read    <= 1'b1;
                        avm_address <= STATUS_ADDR;
                        state       <= POLL_TX;
                    end
                end
                POLL_TX: begin
                    if (xfer_done && avm_readdata[TX_OK_BIT]) begin
                        avm_read    <= 1'b0;
                        avm_write   <= 1'b1;
                        avm_address <= TX_ADDR;
                        state       <= WRITE_TX;
                    end
                end
                WRITE_TX: begin
                    if (xfer_done) begin
                        avm_write   <= 1'b0;
                        avm_read    <= 1'b1;
                        avm_address <= STATUS_ADDR;
                        if (byte_cnt == byte_cnt_t'(BYTES - 2)) begin
                            byte_cnt <= '0;
                            state    <= POLL_RX;  // last of BYTES-1 writes
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                            state    <= POLL_TX;
                        end
                    end
                end
                default: state <= POLL_RX;
            endcase
        end
    end

    // operand and result shift registers
    always_ff @(posedge avm_clk) begin
        if (state == READ_RX && xfer_done) begin
            op_sr <= {op_sr[3*KEY_BITS-9:0], rx_byte};
        end
        if (state == WAIT_CORE && job.finished) begin
            res_sr <= job.result;
        end else if (state == WRITE_TX && xfer_done) begin
            res_sr <= res_sr << 8;
        end
    end

endmodule

// ==== design/rsa_top.sv ====
module rsa_top #(
    parameter int KEY_BITS = 256
) (
    input  logic               avm_clk,
    input  logic               avm_rst,
    output avm_pkg::avm_addr_t avm_address,
    output logic               avm_read,
    input  avm_pkg::avm_data_t avm_readdata,
    output logic               avm_write,
    output avm_pkg::avm_data_t avm_writedata,
    input  logic               avm_waitrequest
);

    rsa_job_if #(.KEY_BITS(KEY_BITS)) job ();

    // bus side, collects operands and sends the result
    rsa_avm_wrapper #(.KEY_BITS(KEY_BITS)) u_wrapper (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_readdata    (avm_readdata),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_waitrequest (avm_waitrequest),
        .job             (job.wrapper)
    );

    // modular exponentiation
    rsa_core #(.KEY_BITS(KEY_BITS)) u_core (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .job     (job.core)
    );

endmodule

// ==== verif/tb_uart_model.sv ====
module tb_uart_model (
    input  logic               avm_clk,
    input  logic               avm_rst,
    input  avm_pkg::avm_addr_t avm_address,
    input  logic               avm_read,
    output avm_pkg::avm_data_t avm_readdata,
    input  logic               avm_write,
    input  avm_pkg::avm_data_t avm_writedata,
    output logic               avm_waitrequest,
    input  logic               rx_push,
    input  rsa_pkg::byte_t     rx_push_data,
    input  logic               rx_flush,
    input  logic               tx_clear,
    input  logic               stall_en,
    input  int                 tx_block_len,
    output int                 rx_pending,
    output int                 tx_count,
    output int                 tx_errors,
    output rsa_pkg::byte_t     tx_log [64]
);
    timeunit 1ns;
    timeprecision 1ps;
    import avm_pkg::*;
    import rsa_pkg::*;

    byte_t      rx_mem [256];  // circular receive queue
    logic [7:0] rx_wr;
    logic [7:0] rx_rd;
    logic       stall_bit;
    int         busy_cnt;      // tx busy while nonzero

    assign avm_waitrequest = stall_en & stall_bit;
    assign rx_pending      = int'(8'(rx_wr - rx_rd));

    always_comb begin
        avm_readdata = '0;
        if (avm_address == RX_ADDR) begin
            avm_readdata[7:0] = rx_mem[rx_rd];
        end else if (avm_address == STATUS_ADDR) begin
            avm_readdata[RX_OK_BIT] = rx_wr != rx_rd;
            avm_readdata[TX_OK_BIT] = busy_cnt == 0;
        end
    end

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            stall_bit <= 1'b0;
        end else begin
            stall_bit <= 1'($urandom_range(0, 1));
        end
    end

    always @(posedge avm_clk) begin
        if (rx_flush) begin
            rx_rd <= rx_wr;
        end else begin
            if (rx_push) begin
                rx_mem[rx_wr] <= rx_push_data;
                rx_wr         <= rx_wr + 8'd1;
            end
            if (avm_read && !avm_waitrequest && avm_address == RX_ADDR && rx_wr != rx_rd) begin
                rx_rd <= rx_rd + 8'd1;
                if (8'(rx_rd + 8'd1) == rx_wr && !rx_push) begin
                    busy_cnt <= tx_block_len;  // last operand byte taken
                end
            end else if (busy_cnt > 0 && (avm_read || avm_write)) begin
                busy_cnt <= busy_cnt - 1;  // hold runs while the master polls
            end
        end
        if (tx_clear) begin
            tx_count  <= 0;
            tx_errors <= 0;
        end else if (avm_write && !avm_waitrequest && avm_address == TX_ADDR) begin
            if (busy_cnt != 0 || avm_writedata[31:8] != '0) begin
                tx_errors <= tx_errors + 1;
            end
            if (tx_count < 64) begin
                tx_log[tx_count] <= avm_writedata[7:0];
            end
            tx_count <= tx_count + 1;
        end
    end

    initial begin
        rx_wr    = '0;
        rx_rd    = '0;
        busy_cnt = 0;
    end

endmodule

// ==== verif/tb_rsa_top.sv ====
module tb_rsa_top;
    timeunit 1ns;
    timeprecision 1ps;
    import avm_pkg::*;
    import rsa_pkg::*;

    localparam int KEY_BITS = 256;
    localparam int OUT_BYTES = KEY_BITS / 8 - 1;
    localparam int TIMEOUT = 400000;

    logic      avm_clk;
    logic      avm_rst;
    avm_addr_t avm_address;
    logic      avm_read;
    avm_data_t avm_readdata;
    logic      avm_write;
    avm_data_t avm_writedata;
    logic      avm_waitrequest;
    logic      rx_push;
    byte_t     rx_push_data;
    logic      rx_flush;
    logic      tx_clear;
    logic      stall_en;
    int        tx_block_len;
    int        rx_pending;
    int        tx_count;
    int        tx_errors;
    byte_t     tx_log [64];
    int        errors;
    int        tests;
    logic [KEY_BITS-1:0] n2, d2, a2, n5, d5, a5;

    always #5 avm_clk = ~avm_clk;

    rsa_top #(.KEY_BITS(KEY_BITS)) dut (.*);

    tb_uart_model u_uart (.*);

    task automatic compare_byte(input string name, input byte_t exp, input byte_t act);
        if (exp !== act) begin
            $display("error %s: expected %02h actual %02h", name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_count(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("error %s: expected %0d writes actual %0d", name, exp, act);
            errors++;
        end
    endtask

    // square-and-multiply on wide values
    task automatic mod_pow(input logic [511:0] b, input logic [511:0] e,
                           input logic [511:0] m, output logic [511:0] r);
        logic [511:0] base;
        base = b % m;
        r = 512'd1;
        for (int i = 0; i < KEY_BITS; i++) begin
            if (e[i]) r = (r * base) % m;
            base = (base * base) % m;
        end
    endtask

    function automatic logic [KEY_BITS-1:0] rand_wide();
        logic [KEY_BITS-1:0] v;
        for (int i = 0; i < KEY_BITS / 32; i++) v[32*i +: 32] = $urandom;
        return v;
    endfunction

    task automatic rand_key(output logic [KEY_BITS-1:0] n, output logic [KEY_BITS-1:0] d,
                            output logic [KEY_BITS-1:0] a);
        n = rand_wide();
        n[KEY_BITS-1:248] = '0;  // below 2^248, odd
        n[0] = 1'b1;
        d = rand_wide();
        a = rand_wide() % n;
    endtask

    task automatic push_operands(input logic [KEY_BITS-1:0] n, input logic [KEY_BITS-1:0] d,
                                 input logic [KEY_BITS-1:0] a);
        logic [KEY_BITS-1:0] op;
        for (int i = 0; i < 3 * (KEY_BITS / 8); i++) begin
            op = (i < 32) ? n : (i < 64) ? d : a;
            @(posedge avm_clk);
            rx_push      <= 1'b1;
            rx_push_data <= op[KEY_BITS-1-8*(i%32) -: 8];  // msb first
        end
        @(posedge avm_clk);
        rx_push <= 1'b0;
    endtask

    task automatic wait_tx(input string name, input int target);
        int cycles;
        cycles = 0;
        while (tx_count < target && cycles < TIMEOUT) begin
            @(posedge avm_clk);
            cycles++;
        end
        if (tx_count < target) begin
            $display("%s: timed out waiting for %0d result bytes, got %0d", name, target, tx_count);
            errors++;
        end
    endtask

    task automatic check_result(input string name, input logic [KEY_BITS-1:0] n,
                                input logic [KEY_BITS-1:0] d, input logic [KEY_BITS-1:0] a,
                                input int base);
        logic [511:0] r;
        mod_pow(512'(a), 512'(d), 512'(n), r);
        for (int i = 0; i < OUT_BYTES; i++) begin
            compare_byte(name, r[247-8*i -: 8], tx_log[base+i]);
        end
    endtask

    task automatic start_test(input logic stall, input int hold);
        @(posedge avm_clk);
        tx_clear     <= 1'b1;
        stall_en     <= stall;
        tx_block_len <= hold;
        @(posedge avm_clk);
        tx_clear <= 1'b0;
    endtask

    task automatic finish_test(input string name, input int err_before, input int writes);
        repeat (40) @(posedge avm_clk);  // no extra writes may follow
        compare_count(name, writes, tx_count);
        if (tx_errors != 0) begin
            $display("%s: %0d writes came while tx was busy or had bad upper bits", name, tx_errors);
            errors++;
        end
        tests++;
        $display("test %s: %s", name, (errors == err_before) ? "pass" : "fail");
        stall_en     <= 1'b0;
        tx_block_len <= 0;
    endtask

    task automatic run_job(input string name, input logic [KEY_BITS-1:0] n,
                           input logic [KEY_BITS-1:0] d, input logic [KEY_BITS-1:0] a,
                           input logic stall, input int hold);
        int err_before;
        err_before = errors;
        start_test(stall, hold);
        push_operands(n, d, a);
        wait_tx(name, OUT_BYTES);
        check_result(name, n, d, a, 0);
        finish_test(name, err_before, OUT_BYTES);
    endtask

    task automatic reset_mid_job();
        int cycles;
        int err_before;
        err_before = errors;
        cycles = 0;
        start_test(1'b0, 0);
        rand_key(n5, d5, a5);
        push_operands(n5, d5, a5);
        while (rx_pending > 50 && cycles < TIMEOUT) begin
            @(posedge avm_clk);
            cycles++;
        end
        if (rx_pending > 50) begin
            $display("reset_mid_job: operand bytes were not being read");
            errors++;
        end
        avm_rst  <= 1'b1;
        rx_flush <= 1'b1;
        @(negedge avm_clk);
        if (avm_read !== 1'b0 || avm_write !== 1'b0) begin
            $display("reset_mid_job: read or write still high during reset");
            errors++;
        end
        @(posedge avm_clk);
        rx_flush <= 1'b0;
        @(posedge avm_clk);
        avm_rst <= 1'b0;
        finish_test("reset_mid_job", err_before, 0);
        rand_key(n5, d5, a5);
        run_job("after_reset", n5, d5, a5, 1'b0, 0);
    endtask

    initial begin
        int err_before;
        avm_clk      = 1'b0;
        avm_rst      = 1'b1;
        rx_push      = 1'b0;
        rx_push_data = '0;
        rx_flush     = 1'b0;
        tx_clear     = 1'b1;
        stall_en     = 1'b0;
        tx_block_len = 0;
        errors       = 0;
        tests        = 0;
        void'($urandom(32'h294c85f0));
        repeat (2) @(posedge avm_clk);
        avm_rst <= 1'b0;

        run_job("small_vector", 256'd1000001, 256'd10, 256'd2, 1'b0, 0);
        rand_key(n2, d2, a2);
        run_job("random_key", n2, d2, a2, 1'b0, 0);
        run_job("back_pressure", n2, d2, a2, 1'b1, 0);
        rand_key(n5, d5, a5);
        run_job("tx_busy", n5, d5, a5, 1'b0, 500);

        err_before = errors;
        start_test(1'b0, 0);
        rand_key(n2, d2, a2);
        rand_key(n5, d5, a5);
        push_operands(n2, d2, a2);
        push_operands(n5, d5, a5);
        wait_tx("back_to_back", 2 * OUT_BYTES);
        check_result("back_to_back", n2, d2, a2, 0);
        check_result("back_to_back", n5, d5, a5, OUT_BYTES);
        finish_test("back_to_back", err_before, 2 * OUT_BYTES);

        reset_mid_job();

        $display("tests run %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== list.f ====
design/avm_pkg.sv
design/rsa_pkg.sv
design/rsa_job_if.sv
design/rsa_prep.sv
design/rsa_mont.sv
design/rsa_core.sv
design/rsa_avm_wrapper.sv
design/rsa_top.sv
verif/tb_uart_model.sv
verif/tb_rsa_top.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the RSA engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module tb_rsa_top -o tb_rsa_top
./obj_dir/tb_rsa_top > sim.log
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
    exit 1
fi
exit 0
